// File: activeList.sv
/*
 * Active list top level
 * Pointer block, entry and done RAMs, recovery register and FSM
 */
`timescale 1ns/1ps

module activeList (
    input  logic                   clk,
    input  logic                   arstN,
    input  logic                   push,
    input  microOpPkg::alEntry     pushEntry,
    input  logic                   wbValid [activeListPkg::laneNum],
    input  activeListPkg::alIndex  wbPtr   [activeListPkg::laneNum],
    input  microOpPkg::execState   wbState [activeListPkg::laneNum],
    output logic                   commitValid,
    output microOpPkg::alEntry     commitEntry,
    output logic                   commitRecover,
    output microOpPkg::refetchKind commitRefetch,
    output logic                   flushValid,
    output activeListPkg::alIndex  flushPtr,
    output microOpPkg::alEntry     flushEntry,
    output logic                   flushBusy,
    output logic                   flushDone,
    output logic                   creditReturn
);

    localparam int doneWriteNum = 1 + activeListPkg::laneNum;

    activeListPkg::alIndex  headPtr;
    activeListPkg::alIndex  tailPtr;
    activeListPkg::alCount  count;
    logic                   pop;
    logic                   unpush;
    logic                   recValid;
    activeListPkg::alIndex  recPtr;
    microOpPkg::refetchKind recKind;
    logic                   wbLive [activeListPkg::laneNum];
    activeListPkg::alIndex  readAddr [2];

    logic                   entryWe [1];
    activeListPkg::alIndex  entryWa [1];
    microOpPkg::alEntry     entryWd [1];
    microOpPkg::alEntry     entryRd [2];

    logic                   doneWe [doneWriteNum];
    activeListPkg::alIndex  doneWa [doneWriteNum];
    logic                   doneWd [doneWriteNum];
    logic                   doneRd [2];

    always_comb begin
        flushPtr = activeListPkg::ptrDec(tailPtr);
        readAddr[0] = headPtr;
        readAddr[1] = flushPtr;

        entryWe[0] = push;
        entryWa[0] = tailPtr;
        entryWd[0] = pushEntry;
        commitEntry = entryRd[0];
        flushEntry  = entryRd[1];

        // Dispatch clears the done bit, lanes set it
        doneWe[0] = push;
        doneWa[0] = tailPtr;
        doneWd[0] = 1'b0;
        for (int l = 0; l < activeListPkg::laneNum; l++) begin
            // Results landing during a flush belong to dropped ops
            wbLive[l] = wbValid[l] && !flushBusy;
            doneWe[l+1] = wbLive[l];
            doneWa[l+1] = wbPtr[l];
            doneWd[l+1] = 1'b1;
        end
    end

    activeListPtr ptr_i (
        .clk(clk), .arstN(arstN), .push(push), .pop(pop), .unpush(unpush),
        .headPtr(headPtr), .tailPtr(tailPtr), .count(count)
    );

    activeListRam #(.writeNum(1), .payloadT(microOpPkg::alEntry)) entryRam_i (
        .clk(clk), .writeEnable(entryWe), .writeAddr(entryWa), .writeData(entryWd),
        .readAddr(readAddr), .readData(entryRd)
    );

    activeListRam #(.writeNum(doneWriteNum), .payloadT(logic)) doneRam_i (
        .clk(clk), .writeEnable(doneWe), .writeAddr(doneWa), .writeData(doneWd),
        .readAddr(readAddr), .readData(doneRd)
    );

    recoveryReg recReg_i (
        .clk(clk), .arstN(arstN), .headPtr(headPtr),
        .wbValid(wbLive), .wbPtr(wbPtr), .wbState(wbState), .commitPop(pop),
        .recValid(recValid), .recPtr(recPtr), .recKind(recKind)
    );

    recoveryFsm fsm_i (
        .clk(clk), .arstN(arstN), .headDone(doneRd[0]), .count(count),
        .recValid(recValid), .recPtr(recPtr), .headPtr(headPtr), .recKind(recKind),
        .commitValid(commitValid), .commitRecover(commitRecover),
        .commitRefetch(commitRefetch), .pop(pop), .unpush(unpush),
        .flushValid(flushValid), .flushBusy(flushBusy), .flushDone(flushDone),
        .creditReturn(creditReturn)
    );

endmodule

// File: activeListPkg.sv
/*
 * Active list sizing: depth, pointer and lane widths
 * Pointer, occupancy and credit types
 * Wrapping pointer helpers and age from the head
 */
package activeListPkg;

    localparam int entryNum   = 16;
    localparam int indexWidth = 4;
    localparam int laneNum    = 2;

    typedef logic [indexWidth-1:0] alIndex;

    // Occupancy 0..entryNum, also used to count dispatch credits
    typedef logic [indexWidth:0] alCount;

    function automatic alIndex ptrInc(alIndex p);
        return (p == alIndex'(entryNum - 1)) ? '0 : alIndex'(p + 1'b1);
    endfunction

    function automatic alIndex ptrDec(alIndex p);
        return (p == '0) ? alIndex'(entryNum - 1) : alIndex'(p - 1'b1);
    endfunction

    // Distance of an entry from the head, 0 for the oldest op
    function automatic alIndex ptrAge(alIndex p, alIndex head);
        if (p >= head) begin
            return alIndex'(p - head);
        end
        return alIndex'(int'(p) + entryNum - int'(head));
    endfunction

endpackage

// File: activeListPtr.sv
/*
 * Head and tail pointers of the active list
 * Occupancy counter, tail can step back during recovery
 */
`timescale 1ns/1ps

module activeListPtr (
    input  logic                  clk,
    input  logic                  arstN,
    input  logic                  push,
    input  logic                  pop,
    input  logic                  unpush,
    output activeListPkg::alIndex headPtr,
    output activeListPkg::alIndex tailPtr,
    output activeListPkg::alCount count
);

    activeListPkg::alIndex headNext;
    activeListPkg::alIndex tailNext;
    activeListPkg::alCount countNext;

    always_comb begin
        headNext = headPtr;
        if (pop) begin
            headNext = activeListPkg::ptrInc(headPtr);
        end

        // Push and unpush never meet, dispatch is stalled while flushing
        tailNext = tailPtr;
        if (push) begin
            tailNext = activeListPkg::ptrInc(tailPtr);
        end else if (unpush) begin
            tailNext = activeListPkg::ptrDec(tailPtr);
        end

        countNext = count;
        if (push) begin
            countNext = countNext + 1'b1;
        end
        if (pop) begin
            countNext = countNext - 1'b1;
        end
        if (unpush) begin
            countNext = countNext - 1'b1;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            headPtr <= '0;
            tailPtr <= '0;
            count   <= '0;
        end else begin
            headPtr <= headNext;
            tailPtr <= tailNext;
            count   <= countNext;
        end
    end

endmodule

// File: activeListRam.sv
/*
 * Distributed entry memory for the active list
 * Several write ports, two asynchronous read ports
 */
`timescale 1ns/1ps

module activeListRam #(
    parameter int  writeNum = 1,
    parameter type payloadT = logic
) (
    input  logic                  clk,
    input  logic                  writeEnable [writeNum],
    input  activeListPkg::alIndex writeAddr   [writeNum],
    input  payloadT               writeData   [writeNum],
    input  activeListPkg::alIndex readAddr    [2],
    output payloadT               readData    [2]
);

    payloadT mem [activeListPkg::entryNum];

    // Higher numbered ports are applied last and win
    always_ff @(posedge clk) begin
        for (int w = 0; w < writeNum; w++) begin
            if (writeEnable[w]) begin
                mem[writeAddr[w]] <= writeData[w];
            end
        end
    end

    always_comb begin
        for (int r = 0; r < 2; r++) begin
            readData[r] = mem[readAddr[r]];
        end
    end

endmodule

// File: activeListTb.sv
/*
 * Testbench for the active list
 * Dispatch and writeback stimulus, queue reference model
 * Per-cycle output comparison and a cycle limit
 */
`timescale 1ns/1ps

module activeListTb;

    localparam int resetOps   = 3;
    localparam int fillOps    = activeListPkg::entryNum;
    localparam int pairOps    = 12;
    localparam int randomOps  = 200;
    localparam int totalOps   = resetOps + fillOps + pairOps + randomOps;
    localparam int cycleLimit = 20 * totalOps + 200;

    typedef struct packed {
        logic                   commitValid;
        microOpPkg::alEntry     commitEntry;
        logic                   commitRecover;
        microOpPkg::refetchKind commitRefetch;
        logic                   flushValid;
        activeListPkg::alIndex  flushPtr;
        microOpPkg::alEntry     flushEntry;
        logic                   flushBusy;
        logic                   flushDone;
        logic                   creditReturn;
    } expectT;

    logic                   clk = 1'b0;
    logic                   arstN;
    logic                   push;
    microOpPkg::alEntry     pushEntry;
    logic                   wbValid [activeListPkg::laneNum];
    activeListPkg::alIndex  wbPtr   [activeListPkg::laneNum];
    microOpPkg::execState   wbState [activeListPkg::laneNum];
    logic                   commitValid;
    microOpPkg::alEntry     commitEntry;
    logic                   commitRecover;
    microOpPkg::refetchKind commitRefetch;
    logic                   flushValid;
    activeListPkg::alIndex  flushPtr;
    microOpPkg::alEntry     flushEntry;
    logic                   flushBusy;
    logic                   flushDone;
    logic                   creditReturn;

    // Reference queue, oldest op first
    microOpPkg::alEntry     qEntry [$];
    activeListPkg::alIndex  qPtr   [$];
    bit                     qDone  [$];
    microOpPkg::execState   qState [$];
    activeListPkg::alIndex  mTail  = '0;
    bit                     mFlush = 1'b0;
    expectT                 expNow;

    int credits  = activeListPkg::entryNum;
    int pushed   = 0;
    int returned = 0;
    int cycles   = 0;

    activeList activeList_i (
        .clk(clk), .arstN(arstN), .push(push), .pushEntry(pushEntry),
        .wbValid(wbValid), .wbPtr(wbPtr), .wbState(wbState),
        .commitValid(commitValid), .commitEntry(commitEntry),
        .commitRecover(commitRecover), .commitRefetch(commitRefetch),
        .flushValid(flushValid), .flushPtr(flushPtr), .flushEntry(flushEntry),
        .flushBusy(flushBusy), .flushDone(flushDone), .creditReturn(creditReturn)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycleLimit) begin
            $display("Timeout after %0d cycles, the active list made no progress", cycles);
            $display("TEST FAIL");
            $fatal(1, "cycle limit reached");
        end
    end

    // Expected outputs for the current cycle from the queue model
    function automatic expectT predictOutputs();
        expectT e;
        e = '0;
        if (mFlush) begin
            e.flushBusy = 1'b1;
            if (qPtr.size() > 0) begin
                e.flushValid = 1'b1;
                e.flushPtr   = qPtr[$];
                e.flushEntry = qEntry[$];
            end else begin
                e.flushDone = 1'b1;
            end
        end else if (qPtr.size() > 0 && qDone[0]) begin
            // The head is the oldest op, so its own refetch is the recorded one
            e.commitValid   = 1'b1;
            e.commitEntry   = qEntry[0];
            e.commitRecover = (qState[0] == microOpPkg::REFETCH_THIS) ||
                              (qState[0] == microOpPkg::REFETCH_NEXT);
            e.commitRefetch = (qState[0] == microOpPkg::REFETCH_NEXT) ?
                              microOpPkg::NEXT_PC : microOpPkg::THIS_PC;
        end
        e.creditReturn = e.commitValid || e.flushValid;
        return e;
    endfunction

    task automatic compareValue(input string name, input logic [63:0] expVal,
                                input logic [63:0] gotVal);
        if (gotVal !== expVal) begin
            $display("Error %s exp 0x%0h got 0x%0h", name, expVal, gotVal);
            $display("TEST FAIL");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // Apply the effect of the coming clock edge to the model
    task automatic updateModel(input expectT e);
        for (int l = 0; l < activeListPkg::laneNum; l++) begin
            if (wbValid[l] && !e.flushBusy) begin
                for (int i = 0; i < qPtr.size(); i++) begin
                    if (qPtr[i] == wbPtr[l]) begin
                        qDone[i]  = 1'b1;
                        qState[i] = wbState[l];
                    end
                end
            end
        end
        if (e.commitValid) begin
            void'(qEntry.pop_front());
            void'(qPtr.pop_front());
            void'(qDone.pop_front());
            void'(qState.pop_front());
            mFlush = e.commitRecover;
        end
        if (e.flushValid) begin
            void'(qEntry.pop_back());
            void'(qPtr.pop_back());
            void'(qDone.pop_back());
            void'(qState.pop_back());
            mTail = activeListPkg::alIndex'(mTail - 1'b1);
        end
        if (e.flushDone) begin
            mFlush = 1'b0;
        end
        if (push) begin
            qEntry.push_back(pushEntry);
            qPtr.push_back(mTail);
            qDone.push_back(1'b0);
            qState.push_back(microOpPkg::NOT_FINISHED);
            mTail = activeListPkg::alIndex'(mTail + 1'b1);
        end
        // The dispatcher regains credits from the DUT's returns
        if (creditReturn) begin
            credits++;
            returned++;
        end
    endtask

    always @(negedge clk) begin
        if (arstN) begin
            expNow = predictOutputs();
            compareValue("commitValid", 64'(expNow.commitValid), 64'(commitValid));
            compareValue("commitRecover", 64'(expNow.commitRecover), 64'(commitRecover));
            if (expNow.commitValid) begin
                compareValue("commitEntry", 64'(expNow.commitEntry), 64'(commitEntry));
            end
            if (expNow.commitRecover) begin
                compareValue("commitRefetch", 64'(expNow.commitRefetch), 64'(commitRefetch));
            end
            compareValue("flushValid", 64'(expNow.flushValid), 64'(flushValid));
            compareValue("flushBusy", 64'(expNow.flushBusy), 64'(flushBusy));
            compareValue("flushDone", 64'(expNow.flushDone), 64'(flushDone));
            compareValue("creditReturn", 64'(expNow.creditReturn), 64'(creditReturn));
            if (expNow.flushValid) begin
                compareValue("flushPtr", 64'(expNow.flushPtr), 64'(flushPtr));
                compareValue("flushEntry", 64'(expNow.flushEntry), 64'(flushEntry));
            end
            updateModel(expNow);
        end
    end

    task automatic clearInputs();
        push      = 1'b0;
        pushEntry = '0;
        for (int l = 0; l < activeListPkg::laneNum; l++) begin
            wbValid[l] = 1'b0;
            wbPtr[l]   = '0;
            wbState[l] = microOpPkg::SUCCESS;
        end
    endtask

    function automatic microOpPkg::execState pickState(input int refetchPct);
        if (int'($urandom_range(99)) < refetchPct) begin
            return ($urandom_range(1) == 1) ? microOpPkg::REFETCH_NEXT : microOpPkg::REFETCH_THIS;
        end
        return microOpPkg::SUCCESS;
    endfunction

    // One cycle of dispatch on credits and random writebacks of open entries
    task automatic trafficCycle(input bit tryPush, input bit doWb, input int refetchPct);
        int cand [$];
        int pick;
        @(posedge clk);
        #1;
        clearInputs();
        if (tryPush && credits > 0 && !flushBusy) begin
            push             = 1'b1;
            pushEntry.pc     = $urandom();
            pushEntry.dstReg = 6'($urandom_range(63));
            pushEntry.isMem  = 1'($urandom_range(1));
            credits--;
            pushed++;
        end
        // Results may also land on entries that a flush is dropping
        if (doWb) begin
            for (int i = 0; i < qPtr.size(); i++) begin
                if (!qDone[i]) begin
                    cand.push_back(i);
                end
            end
            for (int l = 0; l < activeListPkg::laneNum; l++) begin
                if (cand.size() > 0 && $urandom_range(1) == 1) begin
                    pick       = int'($urandom_range(cand.size() - 1));
                    wbValid[l] = 1'b1;
                    wbPtr[l]   = qPtr[cand[pick]];
                    wbState[l] = pickState(refetchPct);
                    cand.delete(pick);
                end
            end
        end
    endtask

    task automatic drain();
        while (qPtr.size() > 0 || mFlush) begin
            trafficCycle(1'b0, 1'b1, 0);
        end
    endtask

    task automatic reportWriteback(input int lane, input int idx,
                                   input microOpPkg::execState st);
        @(posedge clk);
        #1;
        clearInputs();
        wbValid[lane] = 1'b1;
        wbPtr[lane]   = qPtr[idx];
        wbState[lane] = st;
    endtask

    // Refetches on entries 1 and 4, the older one must recover
    task automatic refetchPair(input bit youngerFirst);
        repeat (pairOps / 2) trafficCycle(1'b1, 1'b0, 0);
        if (youngerFirst) begin
            reportWriteback(0, 4, microOpPkg::REFETCH_NEXT);
            reportWriteback(1, 1, microOpPkg::REFETCH_THIS);
        end else begin
            reportWriteback(1, 1, microOpPkg::REFETCH_NEXT);
            reportWriteback(0, 4, microOpPkg::REFETCH_THIS);
        end
        drain();
    endtask

    initial begin
        int target;
        void'($urandom(57));
        arstN = 1'b0;
        clearInputs();
        repeat (5) @(posedge clk);
        #1;
        arstN = 1'b1;

        // No commit while nothing is finished
        repeat (resetOps) trafficCycle(1'b1, 1'b0, 0);
        repeat (6) trafficCycle(1'b0, 1'b0, 0);
        drain();

        while (credits > 0) begin
            trafficCycle(1'b1, 1'b0, 0);
        end
        compareValue("pushed", 64'(resetOps + fillOps), 64'(pushed));
        drain();

        refetchPair(1'b0);
        refetchPair(1'b1);

        target = pushed + randomOps;
        while (pushed < target) begin
            trafficCycle(1'b1, 1'b1, 12);
        end
        drain();

        compareValue("returned", 64'(pushed), 64'(returned));
        compareValue("credits", 64'(activeListPkg::entryNum), 64'(credits));
        $display("TEST PASS");
        $finish;
    end

endmodule

// File: activeList_checker.sv
/*
 * Concurrent assertions bound to the active list
 * Phase exclusion, flushDone pulse, credit and dispatch rules
 */
`timescale 1ns/1ps

module activeListChecker (
    input logic clk,
    input logic arstN,
    input logic push,
    input logic commitValid,
    input logic flushBusy,
    input logic flushDone,
    input logic creditReturn
);

    // Ops pushed and not yet returned as credits
    int inFlight;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            inFlight <= 0;
        end else begin
            inFlight <= inFlight + (push ? 1 : 0) - (creditReturn ? 1 : 0);
        end
    end

    phaseExclusive: assert property (@(posedge clk) disable iff (!arstN)
        !(flushBusy && commitValid))
        else $error("commit and flush active in the same cycle");

    donePulse: assert property (@(posedge clk) disable iff (!arstN)
        flushDone |=> !flushDone)
        else $error("flushDone held for more than one cycle");

    creditBound: assert property (@(posedge clk) disable iff (!arstN)
        creditReturn |-> (inFlight > 0))
        else $error("credit returned with no op in flight");

    noPushInFlush: assert property (@(posedge clk) disable iff (!arstN)
        push |-> !flushBusy)
        else $error("push while a flush is in progress");

endmodule

bind activeList activeListChecker checker_i (
    .clk(clk), .arstN(arstN), .push(push), .commitValid(commitValid),
    .flushBusy(flushBusy), .flushDone(flushDone), .creditReturn(creditReturn)
);

// File: microOpPkg.sv
/*
 * Micro-op definitions shared by the active list
 * Execution state and refetch kind encodings
 * Packed payload kept per active list entry
 */
package microOpPkg;

    localparam int pcWidth  = 32;
    localparam int regWidth = 6;

    // Result reported by a writeback lane
    typedef enum logic [1:0] {
        NOT_FINISHED = 2'd0,
        SUCCESS      = 2'd1,
        REFETCH_THIS = 2'd2,
        REFETCH_NEXT = 2'd3
    } execState;

    // Where the front end restarts after a recovery
    typedef enum logic {
        THIS_PC = 1'b0,
        NEXT_PC = 1'b1
    } refetchKind;

    typedef struct packed {
        logic [pcWidth-1:0]  pc;
        logic [regWidth-1:0] dstReg;
        logic                isMem;
    } alEntry;

endpackage

// File: recoveryFsm.sv
/*
 * Commit and recovery phase control of the active list
 * Commit pops, flush walk from the tail, credit return
 */
`timescale 1ns/1ps

module recoveryFsm (
    input  logic                   clk,
    input  logic                   arstN,
    input  logic                   headDone,
    input  activeListPkg::alCount  count,
    input  logic                   recValid,
    input  activeListPkg::alIndex  recPtr,
    input  activeListPkg::alIndex  headPtr,
    input  microOpPkg::refetchKind recKind,
    output logic                   commitValid,
    output logic                   commitRecover,
    output microOpPkg::refetchKind commitRefetch,
    output logic                   pop,
    output logic                   unpush,
    output logic                   flushValid,
    output logic                   flushBusy,
    output logic                   flushDone,
    output logic                   creditReturn
);

    typedef enum logic {
        COMMIT = 1'b0,
        FLUSH  = 1'b1
    } alPhase;

    alPhase phase;
    alPhase phaseNext;
    logic   queueEmpty;

    always_comb begin
        queueEmpty = (count == '0);

        // Done bit of a free slot may be stale, so check occupancy too
        commitValid   = (phase == COMMIT) && !queueEmpty && headDone;
        commitRecover = commitValid && recValid && (recPtr == headPtr);
        commitRefetch = recKind;
        pop           = commitValid;

        // The recovering op is gone, what is left is younger
        unpush     = (phase == FLUSH) && !queueEmpty;
        flushValid = unpush;
        flushBusy  = (phase == FLUSH);
        flushDone  = (phase == FLUSH) && queueEmpty;

        // One credit per freed entry
        creditReturn = pop || unpush;

        phaseNext = phase;
        case (phase)
            COMMIT: begin
                if (commitRecover) begin
                    phaseNext = FLUSH;
                end
            end
            FLUSH: begin
                if (queueEmpty) begin
                    phaseNext = COMMIT;
                end
            end
            default: begin
                phaseNext = COMMIT;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            phase <= COMMIT;
        end else begin
            phase <= phaseNext;
        end
    end

endmodule

// File: recoveryReg.sv
/*
 * Recovery register of the active list
 * Keeps the oldest refetch reported by the writeback lanes
 * Cleared when the recorded op leaves the head
 */
`timescale 1ns/1ps

module recoveryReg (
    input  logic                       clk,
    input  logic                       arstN,
    input  activeListPkg::alIndex      headPtr,
    input  logic                       wbValid [activeListPkg::laneNum],
    input  activeListPkg::alIndex      wbPtr   [activeListPkg::laneNum],
    input  microOpPkg::execState       wbState [activeListPkg::laneNum],
    input  logic                       commitPop,
    output logic                       recValid,
    output activeListPkg::alIndex      recPtr,
    output microOpPkg::refetchKind     recKind
);

    logic                   nextValid;
    activeListPkg::alIndex  nextPtr;
    microOpPkg::refetchKind nextKind;
    activeListPkg::alIndex  bestAge;
    activeListPkg::alIndex  laneAge [activeListPkg::laneNum];
    logic                   laneRefetch [activeListPkg::laneNum];
    logic                   recordedPops;

    always_comb begin
        nextValid = recValid;
        nextPtr   = recPtr;
        nextKind  = recKind;
        bestAge   = activeListPkg::ptrAge(recPtr, headPtr);

        // Smaller age means older op, lanes never name the same entry
        for (int l = 0; l < activeListPkg::laneNum; l++) begin
            laneAge[l] = activeListPkg::ptrAge(wbPtr[l], headPtr);
            laneRefetch[l] = wbValid[l] &&
                (wbState[l] inside {microOpPkg::REFETCH_THIS, microOpPkg::REFETCH_NEXT});
            if (laneRefetch[l] && (!nextValid || laneAge[l] < bestAge)) begin
                nextValid = 1'b1;
                nextPtr   = wbPtr[l];
                bestAge   = laneAge[l];
                if (wbState[l] == microOpPkg::REFETCH_NEXT) begin
                    nextKind = microOpPkg::NEXT_PC;
                end else begin
                    nextKind = microOpPkg::THIS_PC;
                end
            end
        end

        // Anything younger is flushed anyway, so clearing wins
        recordedPops = commitPop && recValid && (recPtr == headPtr);
        if (recordedPops) begin
            nextValid = 1'b0;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            recValid <= 1'b0;
            recPtr   <= '0;
            recKind  <= microOpPkg::THIS_PC;
        end else begin
            recValid <= nextValid;
            recPtr   <= nextPtr;
            recKind  <= nextKind;
        end
    end

endmodule

// File: run.sh
#!/bin/sh
# Build and run the active list testbench with Verilator

cd "$(dirname "$0")" || exit 1

OBJ=obj_dir
LOG=sim.log

verilator --binary -Wno-fatal --top-module activeListTb -f vlog.f \
    --Mdir "$OBJ" -o activeListSim > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "Build failed, see build.log"
    exit 1
fi

"./$OBJ/activeListSim" > "$LOG" 2>&1
simStatus=$?

if grep -q "TEST FAIL" "$LOG"; then
    echo "Simulation failed, see $LOG"
    exit 1
fi
if [ $simStatus -ne 0 ]; then
    echo "Simulation ended with status $simStatus, see $LOG"
    exit 1
fi
echo "Simulation passed"
exit 0

// File: vlog.f
activeListPkg.sv
microOpPkg.sv
activeListPtr.sv
activeListRam.sv
recoveryReg.sv
recoveryFsm.sv
activeList.sv
activeList_checker.sv
activeListTb.sv
